//--- build.f
+incdir+.
stream_writer_pkg.sv
host_cmd_pkg.sv
sync_fifo.sv
transfer_splitter.sv
transfer_sequencer.sv
stream_writer.sv
tb_stream_writer.sv

//--- host_cmd_pkg.sv
`include "stream_writer_params.svh"

package host_cmd_pkg;

    // Host virtual address, also used for buffer sizes and byte counts
    typedef logic [`SW_VADDR_BITS-1:0] vaddr_t;

    // Request opcodes understood by the host; only local writes are issued
    typedef enum logic [4:0] {
        LOCAL_WRITE = 5'd2
    } req_opcode_t;

    // Notify word layout
    localparam int NOTIFY_BITS      = 32;
    localparam int NOTIFY_ID_LSB    = 0;
    localparam int NOTIFY_ID_MSB    = 2;
    // Bytes written to the buffer, 28 bits wide
    localparam int NOTIFY_BYTES_LSB = 3;
    localparam int NOTIFY_BYTES_MSB = 30;
    localparam int NOTIFY_LAST_BIT  = 31;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module tb_stream_writer -o sim_stream_writer

output=$(./obj_dir/sim_stream_writer) || true
printf '%s\n' "$output"

printf '%s\n' "$output" | grep -q "^RESULT: PASS$"

//--- stream_writer.sv
`timescale 1ns/1ps
`include "stream_writer_params.svh"

module stream_writer (
    input  logic                                 clk,
    input  logic                                 reset_synced,
    input  logic                                 i_in_valid,
    input  logic [`SW_DATA_BITS-1:0]             i_in_data,
    input  logic [`SW_DATA_BYTES-1:0]            i_in_keep,
    input  logic                                 i_in_last,
    output logic                                 o_in_ready,
    input  logic                                 i_buf_valid,
    input  host_cmd_pkg::vaddr_t                 i_buf_vaddr,
    input  host_cmd_pkg::vaddr_t                 i_buf_size,
    output logic                                 o_buf_ready,
    output logic                                 o_req_valid,
    output host_cmd_pkg::req_opcode_t            o_req_opcode,
    output host_cmd_pkg::vaddr_t                 o_req_vaddr,
    output stream_writer_pkg::len_t              o_req_len,
    input  logic                                 i_req_ready,
    input  logic                                 i_cpl_valid,
    output logic                                 o_notify_valid,
    output logic [host_cmd_pkg::NOTIFY_BITS-1:0] o_notify_value,
    input  logic                                 i_notify_ready,
    output logic                                 o_out_valid,
    output logic [`SW_DATA_BITS-1:0]             o_out_data,
    output logic [`SW_DATA_BYTES-1:0]            o_out_keep,
    output logic                                 o_out_last,
    input  logic                                 i_out_ready
);

    // A data FIFO entry packs last, keep and data
    localparam int DAT_W = `SW_DATA_BITS + `SW_DATA_BYTES + 1;

    logic                     dat_wr_ready;
    logic                     len_wr_ready;
    logic                     beat_fire;
    logic                     split_valid;
    stream_writer_pkg::len_t  split_len;
    logic                     dat_rd_valid;
    logic [DAT_W-1:0]         dat_rd_data;
    logic                     dat_rd_ready;
    logic                     len_rd_valid;
    stream_writer_pkg::len_t  len_rd_data;
    logic                     len_rd_ready;

    // A beat enters only when both FIFOs have room, so a closing length is never lost
    assign o_in_ready = dat_wr_ready && len_wr_ready;
    assign beat_fire  = i_in_valid && o_in_ready;

    transfer_splitter u_splitter (
        .clk          (clk),
        .reset_synced (reset_synced),
        .i_beat_fire  (beat_fire),
        .i_in_keep    (i_in_keep),
        .i_in_last    (i_in_last),
        .o_len_valid  (split_valid),
        .o_len        (split_len)
    );

    sync_fifo #(
        .WIDTH (DAT_W),
        .DEPTH (`SW_DATA_FIFO_DEPTH)
    ) data_fifo (
        .clk          (clk),
        .reset_synced (reset_synced),
        .i_wr_valid   (beat_fire),
        .i_wr_data    ({i_in_last, i_in_keep, i_in_data}),
        .o_wr_ready   (dat_wr_ready),
        .o_rd_valid   (dat_rd_valid),
        .o_rd_data    (dat_rd_data),
        .i_rd_ready   (dat_rd_ready)
    );

    sync_fifo #(
        .WIDTH (`SW_LEN_BITS),
        .DEPTH (`SW_LEN_FIFO_DEPTH)
    ) len_fifo (
        .clk          (clk),
        .reset_synced (reset_synced),
        .i_wr_valid   (split_valid),
        .i_wr_data    (split_len),
        .o_wr_ready   (len_wr_ready),
        .o_rd_valid   (len_rd_valid),
        .o_rd_data    (len_rd_data),
        .i_rd_ready   (len_rd_ready)
    );

    transfer_sequencer u_sequencer (
        .clk            (clk),
        .reset_synced   (reset_synced),
        .i_len_valid    (len_rd_valid),
        .i_len          (len_rd_data),
        .o_len_ready    (len_rd_ready),
        .i_dat_valid    (dat_rd_valid),
        .i_dat_data     (dat_rd_data[`SW_DATA_BITS-1:0]),
        .i_dat_keep     (dat_rd_data[DAT_W-2:`SW_DATA_BITS]),
        .i_dat_last     (dat_rd_data[DAT_W-1]),
        .o_dat_ready    (dat_rd_ready),
        .i_buf_valid    (i_buf_valid),
        .i_buf_vaddr    (i_buf_vaddr),
        .i_buf_size     (i_buf_size),
        .o_buf_ready    (o_buf_ready),
        .o_req_valid    (o_req_valid),
        .o_req_opcode   (o_req_opcode),
        .o_req_vaddr    (o_req_vaddr),
        .o_req_len      (o_req_len),
        .i_req_ready    (i_req_ready),
        .i_cpl_valid    (i_cpl_valid),
        .o_notify_valid (o_notify_valid),
        .o_notify_value (o_notify_value),
        .i_notify_ready (i_notify_ready),
        .o_out_valid    (o_out_valid),
        .o_out_data     (o_out_data),
        .o_out_keep     (o_out_keep),
        .o_out_last     (o_out_last),
        .i_out_ready    (i_out_ready)
    );

endmodule

//--- stream_writer_params.svh
`ifndef STREAM_WRITER_PARAMS_SVH
`define STREAM_WRITER_PARAMS_SVH

// Bytes carried by one data beat
`define SW_DATA_BYTES 4
`define SW_DATA_BITS (`SW_DATA_BYTES * 8)

// Largest host transfer in bytes, a whole number of beats
`define SW_TRANSFER_BYTES 16

// A transfer length must be able to hold SW_TRANSFER_BYTES itself
`define SW_LEN_BITS ($clog2(`SW_TRANSFER_BYTES) + 1)

// The data FIFO holds two full transfers so input can run ahead of the host
`define SW_DATA_FIFO_DEPTH (2 * `SW_TRANSFER_BYTES / `SW_DATA_BYTES)
`define SW_LEN_FIFO_DEPTH 16

// Host virtual addresses and buffer sizes
`define SW_VADDR_BITS 32

// Stream id reported in every notify word, 3 bits wide
`define SW_STREAM_ID 3'd5

`endif

//--- stream_writer_pkg.sv
`include "stream_writer_params.svh"

package stream_writer_pkg;

    // Sequencer states, from taking a buffer to notifying the host
    typedef enum logic [2:0] {
        WAIT_FOR_BUFFER = 3'd0,
        // One request per transfer is issued here
        REQUEST         = 3'd1,
        // Beats of the current transfer are forwarded
        TRANSFER        = 3'd2,
        // Outstanding writes are drained before the host is told
        WAIT_COMPLETION = 3'd3,
        WAIT_NOTIFY     = 3'd4
    } seq_state_t;

    // Byte length of one transfer, zero up to SW_TRANSFER_BYTES
    typedef logic [`SW_LEN_BITS-1:0] len_t;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset_synced,
    input  logic             i_wr_valid,
    input  logic [WIDTH-1:0] i_wr_data,
    output logic             o_wr_ready,
    output logic             o_rd_valid,
    output logic [WIDTH-1:0] o_rd_data,
    input  logic             i_rd_ready
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                wr_fire;
    logic                rd_fire;

    // Full and empty come straight from the occupancy count
    assign o_wr_ready = (count != (PTR_BITS+1)'(DEPTH));
    assign o_rd_valid = (count != '0);
    // First word fall through, the head entry is always on the output
    assign o_rd_data  = mem[rd_ptr];

    assign wr_fire = i_wr_valid && o_wr_ready;
    assign rd_fire = o_rd_valid && i_rd_ready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly so any depth works
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A push and a pop in one cycle leave the count unchanged
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- tb_stream_writer.sv
`timescale 1ns/1ps
`include "stream_writer_params.svh"

module tb_stream_writer;

    localparam int NUM_STREAMS        = 12;
    localparam int NUM_BUFS           = 128;
    localparam int BEATS_PER_TRANSFER = `SW_TRANSFER_BYTES / `SW_DATA_BYTES;

    logic                                 clk;
    logic                                 reset_synced;
    logic                                 i_in_valid;
    logic [`SW_DATA_BITS-1:0]             i_in_data;
    logic [`SW_DATA_BYTES-1:0]            i_in_keep;
    logic                                 i_in_last;
    logic                                 o_in_ready;
    logic                                 i_buf_valid;
    host_cmd_pkg::vaddr_t                 i_buf_vaddr;
    host_cmd_pkg::vaddr_t                 i_buf_size;
    logic                                 o_buf_ready;
    logic                                 o_req_valid;
    host_cmd_pkg::req_opcode_t            o_req_opcode;
    host_cmd_pkg::vaddr_t                 o_req_vaddr;
    stream_writer_pkg::len_t              o_req_len;
    logic                                 i_req_ready;
    logic                                 i_cpl_valid;
    logic                                 o_notify_valid;
    logic [host_cmd_pkg::NOTIFY_BITS-1:0] o_notify_value;
    logic                                 i_notify_ready;
    logic                                 o_out_valid;
    logic [`SW_DATA_BITS-1:0]             o_out_data;
    logic [`SW_DATA_BYTES-1:0]            o_out_keep;
    logic                                 o_out_last;
    logic                                 i_out_ready;

    // Input beats in send order, then what the host side should see
    logic [`SW_DATA_BITS-1:0]  in_data [$];
    logic [`SW_DATA_BYTES-1:0] in_keep [$];
    logic                      in_last [$];
    logic [`SW_DATA_BITS-1:0]  exp_data [$];
    logic [`SW_DATA_BYTES-1:0] exp_keep [$];
    logic                      exp_last [$];
    host_cmd_pkg::vaddr_t      exp_req_addr [$];
    int                        exp_req_len [$];
    logic [31:0]               exp_notify [$];
    // Buffers the host offers, taken strictly in this order
    host_cmd_pkg::vaddr_t      buf_addr [NUM_BUFS];
    host_cmd_pkg::vaddr_t      buf_size [NUM_BUFS];
    // Cycle numbers at which the host returns a completion
    int                        cpl_due [$];

    // Reference model of the splitter and the buffer bookkeeping
    logic                      model_have_buf;
    host_cmd_pkg::vaddr_t      model_addr;
    host_cmd_pkg::vaddr_t      model_size;
    host_cmd_pkg::vaddr_t      model_written;
    int                        model_buf_idx;
    int                        model_count;

    int          cycle, in_idx, buf_idx, last_due, timeout_limit;
    int          req_seen, cpl_seen;
    logic        in_fire;

    stream_writer uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // Notify word is stream id in bits 2:0, bytes in 30:3 and the last flag in 31
    task automatic expect_notify(input logic last_bit);
        exp_notify.push_back({last_bit, model_written[27:0], `SW_STREAM_ID});
    endtask

    task automatic close_transfer(input int len, input logic last_bit);
        if (!model_have_buf) begin
            model_addr     = buf_addr[model_buf_idx];
            model_size     = buf_size[model_buf_idx];
            model_buf_idx  = model_buf_idx + 1;
            model_written  = '0;
            model_have_buf = 1'b1;
        end
        if (len == 0) begin
            // No request at all, and an untouched buffer stays for the next stream
            expect_notify(1'b1);
            model_have_buf = (model_written == '0);
        end else begin
            exp_req_addr.push_back(model_addr);
            exp_req_len.push_back(len);
            model_addr    = model_addr + host_cmd_pkg::vaddr_t'(len);
            model_written = model_written + host_cmd_pkg::vaddr_t'(len);
            if (last_bit || (model_written + host_cmd_pkg::vaddr_t'(`SW_TRANSFER_BYTES) >
                             model_size)) begin
                expect_notify(last_bit);
                model_have_buf = 1'b0;
            end
        end
    endtask

    task automatic add_beat(input logic [`SW_DATA_BYTES-1:0] keep, input int nbytes,
                            input logic last_bit);
        logic [`SW_DATA_BITS-1:0] data;
        logic                     split;
        data = $urandom;
        in_data.push_back(data);
        in_keep.push_back(keep);
        in_last.push_back(last_bit);
        model_count = model_count + nbytes;
        split = (model_count == `SW_TRANSFER_BYTES) || last_bit;
        // Only an empty last beat opening a transfer leaves model_count at zero
        if (model_count != 0) begin
            exp_data.push_back(data);
            exp_keep.push_back(keep);
            exp_last.push_back(split);
        end
        if (split) begin
            close_transfer(model_count, last_bit);
            model_count = 0;
        end
    endtask

    task automatic build_stimulus();
        int                        full_beats;
        int                        tail_bytes;
        logic                      empty_end;
        logic [`SW_DATA_BYTES-1:0] keep;
        for (int i = 0; i < NUM_BUFS; i++) begin
            buf_addr[i] = $urandom & 32'h7fff_fff0;
            // The first buffer holds one transfer, so stream 0 fills it exactly
            buf_size[i] = host_cmd_pkg::vaddr_t'(`SW_TRANSFER_BYTES *
                                                 ((i == 0) ? 1 : int'($urandom_range(1, 3))));
        end
        for (int s = 0; s < NUM_STREAMS; s++) begin
            empty_end  = (s == 0) || ($urandom_range(0, 3) == 0);
            full_beats = (s == 0) ? BEATS_PER_TRANSFER : int'($urandom_range(0, 18));
            if (empty_end) begin
                // An empty last beat must start a transfer
                full_beats = (full_beats / BEATS_PER_TRANSFER) * BEATS_PER_TRANSFER;
            end
            for (int b = 0; b < full_beats; b++) begin
                add_beat('1, `SW_DATA_BYTES, 1'b0);
            end
            tail_bytes = empty_end ? 0 : int'($urandom_range(1, `SW_DATA_BYTES));
            keep = '1;
            keep = keep >> (`SW_DATA_BYTES - tail_bytes);
            add_beat(tail_bytes == 0 ? '0 : keep, tail_bytes, 1'b1);
        end
    endtask

    task automatic sample_outputs();
        int due;
        cycle   = cycle + 1;
        in_fire = i_in_valid && o_in_ready;
        if (in_fire) begin
            in_idx = in_idx + 1;
        end
        if (i_buf_valid && o_buf_ready) begin
            buf_idx = buf_idx + 1;
        end
        if (o_req_valid && i_req_ready) begin
            if (exp_req_addr.size() == 0) begin
                fail_run("A write request arrived when no transfer was left to request");
            end
            check_value("req_opcode", 64'(host_cmd_pkg::LOCAL_WRITE), 64'(o_req_opcode));
            check_value("req_vaddr", 64'(exp_req_addr[0]), 64'(o_req_vaddr));
            check_value("req_len", 64'(exp_req_len[0]), 64'(o_req_len));
            exp_req_addr.delete(0);
            exp_req_len.delete(0);
            req_seen = req_seen + 1;
            // Completions return in order, at most one per cycle
            due = cycle + int'($urandom_range(1, 8));
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            cpl_due.push_back(due);
        end
        if (o_notify_valid && i_notify_ready) begin
            if (exp_notify.size() == 0) begin
                fail_run("A notify arrived when none was expected");
            end
            check_value("notify_after_completions", 64'(req_seen), 64'(cpl_seen));
            check_value("notify_value", 64'(exp_notify[0]), 64'(o_notify_value));
            exp_notify.delete(0);
        end
        if (i_cpl_valid) begin
            cpl_seen = cpl_seen + 1;
        end
        if (o_out_valid && i_out_ready) begin
            if (exp_data.size() == 0) begin
                fail_run("An output beat arrived after all expected beats were seen");
            end
            check_value("out_data", 64'(exp_data[0]), 64'(o_out_data));
            check_value("out_keep", 64'(exp_keep[0]), 64'(o_out_keep));
            check_value("out_last", 64'(exp_last[0]), 64'(o_out_last));
            exp_data.delete(0);
            exp_keep.delete(0);
            exp_last.delete(0);
        end
    endtask

    task automatic drive_inputs();
        // A beat that was not taken stays on the bus unchanged
        if (!i_in_valid || in_fire) begin
            i_in_valid = 1'b0;
            if ((in_idx < in_data.size()) && ($urandom_range(0, 3) != 0)) begin
                i_in_valid = 1'b1;
                i_in_data  = in_data[in_idx];
                i_in_keep  = in_keep[in_idx];
                i_in_last  = in_last[in_idx];
            end
        end
        i_buf_valid = (buf_idx < NUM_BUFS);
        if (buf_idx < NUM_BUFS) begin
            i_buf_vaddr = buf_addr[buf_idx];
            i_buf_size  = buf_size[buf_idx];
        end
        i_out_ready    = ($urandom_range(0, 3) != 0);
        i_req_ready    = ($urandom_range(0, 2) != 0);
        i_notify_ready = ($urandom_range(0, 2) != 0);
        i_cpl_valid    = 1'b0;
        if ((cpl_due.size() != 0) && (cpl_due[0] <= cycle)) begin
            i_cpl_valid = 1'b1;
            cpl_due.delete(0);
        end
    endtask

    function automatic bit all_done();
        return (in_idx == in_data.size()) && (exp_data.size() == 0) &&
               (exp_req_addr.size() == 0) && (exp_notify.size() == 0) && (cpl_due.size() == 0);
    endfunction

    initial begin
        reset_synced   = 1'b0;
        i_in_valid     = 1'b0;
        i_in_data      = '0;
        i_in_keep      = '0;
        i_in_last      = 1'b0;
        i_buf_valid    = 1'b0;
        i_buf_vaddr    = '0;
        i_buf_size     = '0;
        i_req_ready    = 1'b0;
        i_cpl_valid    = 1'b0;
        i_notify_ready = 1'b0;
        i_out_ready    = 1'b0;
        in_fire        = 1'b0;
        model_have_buf = 1'b0;
        void'($urandom(35));
        build_stimulus();
        timeout_limit = 40 * in_data.size() + 2000;
        repeat (3) @(posedge clk);
        #1;
        reset_synced = 1'b1;
        while (!all_done()) begin
            @(posedge clk);
            sample_outputs();
            #1;
            drive_inputs();
            if (cycle > timeout_limit) begin
                fail_run("Timeout: the DUT stopped before all expected traffic was seen");
            end
        end
        // Run on past the expected traffic so an extra beat, request or notify is caught
        repeat (50) begin
            @(posedge clk);
            sample_outputs();
            #1;
            drive_inputs();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- transfer_sequencer.sv
`timescale 1ns/1ps
`include "stream_writer_params.svh"

module transfer_sequencer (
    input  logic                                     clk,
    input  logic                                     reset_synced,
    input  logic                                     i_len_valid,
    input  stream_writer_pkg::len_t                  i_len,
    output logic                                     o_len_ready,
    input  logic                                     i_dat_valid,
    input  logic [`SW_DATA_BITS-1:0]                 i_dat_data,
    input  logic [`SW_DATA_BYTES-1:0]                i_dat_keep,
    input  logic                                     i_dat_last,
    output logic                                     o_dat_ready,
    input  logic                                     i_buf_valid,
    input  host_cmd_pkg::vaddr_t                     i_buf_vaddr,
    input  host_cmd_pkg::vaddr_t                     i_buf_size,
    output logic                                     o_buf_ready,
    output logic                                     o_req_valid,
    output host_cmd_pkg::req_opcode_t                o_req_opcode,
    output host_cmd_pkg::vaddr_t                     o_req_vaddr,
    output stream_writer_pkg::len_t                  o_req_len,
    input  logic                                     i_req_ready,
    input  logic                                     i_cpl_valid,
    output logic                                     o_notify_valid,
    output logic [host_cmd_pkg::NOTIFY_BITS-1:0]     o_notify_value,
    input  logic                                     i_notify_ready,
    output logic                                     o_out_valid,
    output logic [`SW_DATA_BITS-1:0]                 o_out_data,
    output logic [`SW_DATA_BYTES-1:0]                o_out_keep,
    output logic                                     o_out_last,
    input  logic                                     i_out_ready
);

    localparam int BEAT_BITS = $clog2(`SW_DATA_BYTES);

    stream_writer_pkg::seq_state_t state;
    // Write address of the next transfer and the size of the buffer
    host_cmd_pkg::vaddr_t          vaddr;
    host_cmd_pkg::vaddr_t          alloc_size;
    host_cmd_pkg::vaddr_t          bytes_written;
    host_cmd_pkg::vaddr_t          num_requests;
    host_cmd_pkg::vaddr_t          num_completions;
    logic                          last_flag;
    stream_writer_pkg::len_t       beat_count;
    stream_writer_pkg::len_t       beats_needed;
    logic                          final_beat;
    logic                          out_fire;
    logic                          zero_len;
    logic                          drop_empty;
    logic                          buffer_full;

    // Beats in the head transfer, with a partial tail beat rounded up
    assign beats_needed = (i_len >> BEAT_BITS) + stream_writer_pkg::len_t'(|i_len[BEAT_BITS-1:0]);
    assign final_beat   = (beat_count + 1'b1) == beats_needed;

    assign zero_len = i_len_valid && (i_len == '0);
    // The empty last beat that produced a zero length is dropped with it
    assign drop_empty = (state == stream_writer_pkg::REQUEST) && zero_len && i_dat_valid;

    // The buffer cannot take another full transfer
    assign buffer_full = (bytes_written + host_cmd_pkg::vaddr_t'(`SW_TRANSFER_BYTES)) > alloc_size;

    assign o_buf_ready = (state == stream_writer_pkg::WAIT_FOR_BUFFER);

    // Requests always describe one local write of the head length
    assign o_req_valid  = (state == stream_writer_pkg::REQUEST) && i_len_valid && (i_len != '0);
    assign o_req_opcode = host_cmd_pkg::LOCAL_WRITE;
    assign o_req_vaddr  = vaddr;
    assign o_req_len    = i_len;

    // Beats pass only while a transfer is open, last marks its final beat
    assign o_out_valid = (state == stream_writer_pkg::TRANSFER) && i_dat_valid;
    assign o_out_data  = i_dat_data;
    assign o_out_keep  = i_dat_keep;
    assign o_out_last  = final_beat;
    assign out_fire    = o_out_valid && i_out_ready;

    assign o_dat_ready = ((state == stream_writer_pkg::TRANSFER) && i_out_ready) || drop_empty;

    // The length stays at the FIFO head until its transfer is fully sent
    assign o_len_ready = (out_fire && final_beat) || drop_empty;

    // The host hears about the buffer only once every write to it has completed
    assign o_notify_valid = (state == stream_writer_pkg::WAIT_NOTIFY) &&
                            (num_completions == num_requests);

    always_comb begin
        o_notify_value = '0;
        o_notify_value[host_cmd_pkg::NOTIFY_ID_MSB:host_cmd_pkg::NOTIFY_ID_LSB] = `SW_STREAM_ID;
        o_notify_value[host_cmd_pkg::NOTIFY_BYTES_MSB:host_cmd_pkg::NOTIFY_BYTES_LSB] =
            bytes_written[host_cmd_pkg::NOTIFY_BYTES_MSB-host_cmd_pkg::NOTIFY_BYTES_LSB:0];
        o_notify_value[host_cmd_pkg::NOTIFY_LAST_BIT] = last_flag;
    end

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            state           <= stream_writer_pkg::WAIT_FOR_BUFFER;
            bytes_written   <= '0;
            num_requests    <= '0;
            num_completions <= '0;
            last_flag       <= 1'b0;
        end else begin
            // Completions may arrive in any state while requests are in flight
            if (i_cpl_valid) begin
                num_completions <= num_completions + 1'b1;
            end
            case (state)
                stream_writer_pkg::WAIT_FOR_BUFFER: begin
                    if (i_buf_valid) begin
                        vaddr           <= i_buf_vaddr;
                        alloc_size      <= i_buf_size;
                        bytes_written   <= '0;
                        num_requests    <= '0;
                        num_completions <= '0;
                        last_flag       <= 1'b0;
                        state           <= stream_writer_pkg::REQUEST;
                    end
                end
                stream_writer_pkg::REQUEST: begin
                    if (o_req_valid && i_req_ready) begin
                        vaddr         <= vaddr + host_cmd_pkg::vaddr_t'(i_len);
                        bytes_written <= bytes_written + host_cmd_pkg::vaddr_t'(i_len);
                        num_requests  <= num_requests + 1'b1;
                        beat_count    <= '0;
                        state         <= stream_writer_pkg::TRANSFER;
                    end else if (drop_empty) begin
                        // Nothing to write, the host only hears that the stream ended
                        last_flag <= 1'b1;
                        state     <= stream_writer_pkg::WAIT_NOTIFY;
                    end
                end
                stream_writer_pkg::TRANSFER: begin
                    if (out_fire) begin
                        beat_count <= beat_count + 1'b1;
                        if (final_beat) begin
                            if (i_dat_last || buffer_full) begin
                                last_flag <= i_dat_last;
                                state     <= stream_writer_pkg::WAIT_COMPLETION;
                            end else begin
                                state <= stream_writer_pkg::REQUEST;
                            end
                        end
                    end
                end
                stream_writer_pkg::WAIT_COMPLETION: begin
                    if (num_completions == num_requests) begin
                        state <= stream_writer_pkg::WAIT_NOTIFY;
                    end
                end
                stream_writer_pkg::WAIT_NOTIFY: begin
                    if (o_notify_valid && i_notify_ready) begin
                        // An untouched buffer is kept for the next stream
                        if (bytes_written == '0) begin
                            last_flag <= 1'b0;
                            state     <= stream_writer_pkg::REQUEST;
                        end else begin
                            state <= stream_writer_pkg::WAIT_FOR_BUFFER;
                        end
                    end
                end
                default: state <= stream_writer_pkg::WAIT_FOR_BUFFER;
            endcase
        end
    end

endmodule

//--- transfer_splitter.sv
`timescale 1ns/1ps
`include "stream_writer_params.svh"

module transfer_splitter (
    input  logic                      clk,
    input  logic                      reset_synced,
    input  logic                      i_beat_fire,
    input  logic [`SW_DATA_BYTES-1:0] i_in_keep,
    input  logic                      i_in_last,
    output logic                      o_len_valid,
    output stream_writer_pkg::len_t   o_len
);

    // Bytes collected so far in the transfer being built
    stream_writer_pkg::len_t byte_count;
    stream_writer_pkg::len_t byte_count_next;
    logic                    is_split;

    // Input is normalized, so the keep popcount is the byte count of the beat
    assign byte_count_next = byte_count + stream_writer_pkg::len_t'($countones(i_in_keep));

    // A transfer closes when it is full or the stream ends
    // An empty last beat at the start of a transfer closes it with length 0
    assign is_split = (byte_count_next == stream_writer_pkg::len_t'(`SW_TRANSFER_BYTES))
                      || i_in_last;

    // The length goes into its FIFO in the same cycle as the closing beat
    assign o_len_valid = i_beat_fire && is_split;
    assign o_len       = byte_count_next;

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            byte_count <= '0;
        end else if (i_beat_fire) begin
            byte_count <= is_split ? '0 : byte_count_next;
        end
    end

endmodule
